// File: Makefile
# Verilator build and run of the signal capture testbench

SOURCES := $(wildcard logic/*.sv tests/*.sv)

obj_dir/Vsignal_capture_tb: project.f $(SOURCES)
	verilator --binary --timing --top-module signal_capture_tb -f project.f

# the run fails when the log holds the fail message or no pass message
run: obj_dir/Vsignal_capture_tb
	./obj_dir/Vsignal_capture_tb | tee sim.log
	! grep -q "Result: FAILED" sim.log
	grep -q "Result: PASSED" sim.log

check: run

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean

// File: logic/capture_pkg.sv
package capture_pkg;

   // ######################################################################
   // geometry of the sampled antenna bus

   localparam int channels     = 24;                 // one-bit antenna channels
   localparam int ratio        = 12;                 // clock cycles per symbol
   localparam int phase_width  = $clog2(ratio);      // holds a phase 0 .. ratio-1
   localparam int max_skew     = 3;                  // worst channel-to-channel offset
   localparam int sync_latency = 2;                  // pin to edge pulse, in cycles

   typedef logic [phase_width-1:0] phase_t;          // one position inside a symbol

   localparam phase_t last_phase = phase_t'(ratio - 1);  // counter wraps after this
   localparam phase_t half_ratio = phase_t'(ratio / 2);  // half a symbol, mid-bit offset
   localparam phase_t full_ratio = phase_t'(ratio);      // ratio itself still fits phase_t

   // ######################################################################
   // modulo arithmetic on the symbol circle

   function automatic phase_t phase_add(input phase_t a, input phase_t b);
      logic [phase_width:0] sum;
      sum = {1'b0, a} + {1'b0, b};                   // both inputs below ratio
      if (sum >= {1'b0, full_ratio}) begin
         sum = sum - {1'b0, full_ratio};             // wrap once around the symbol
      end
      return sum[phase_width-1:0];
   endfunction

   function automatic phase_t phase_dist(input phase_t a, input phase_t b);
      phase_t diff;
      diff = (a >= b) ? a - b : b - a;               // plain distance first
      if (diff > half_ratio) begin
         diff = full_ratio - diff;                   // the short way round is shorter
      end
      return diff;
   endfunction

endpackage

// File: logic/capture_sync.sv
`timescale 1ns/100ps

module capture_sync (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             enable,
   input  logic [capture_pkg::channels-1:0] signal_in,
   output logic [capture_pkg::channels-1:0] synced,
   output logic [capture_pkg::channels-1:0] edge_pulse
);

   logic [capture_pkg::channels-1:0] chain [capture_pkg::sync_latency]; // sync flops
   logic [capture_pkg::channels-1:0] previous;   // last synced level, for edge compare

   // ######################################################################
   // synchroniser chain and edge register

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int s = 0; s < capture_pkg::sync_latency; s++) begin
            chain[s] <= '0;                      // all cleared so no false edge appears
         end
         previous <= '0;
      end else if (enable) begin
         chain[0] <= signal_in;                  // first flop may go metastable
         for (int s = 1; s < capture_pkg::sync_latency; s++) begin
            chain[s] <= chain[s-1];
         end
         previous <= synced;                     // one cycle behind the synced level
      end
   end

   assign synced = chain[capture_pkg::sync_latency-1];  // last flop is the clean level

   // any transition gives a one-cycle pulse, none while the stage is held
   assign edge_pulse = (synced ^ previous) & {capture_pkg::channels{enable}};

endmodule

// File: logic/lock_pkg.sv
package lock_pkg;

   // ######################################################################
   // lock policy of the per-channel phase estimators

   localparam int lock_edges       = 8;              // consistent edges before lock
   localparam int phase_tolerance  = 1;              // allowed edge jitter, in cycles
   localparam int confidence_width = 4;              // per-channel edge counter width

   typedef logic [confidence_width-1:0] confidence_t;

   localparam confidence_t confidence_full = '1;                          // saturation
   localparam confidence_t lock_target = confidence_t'(lock_edges);       // locked count
   localparam confidence_t lock_arm    = confidence_t'(lock_edges - 1);   // one edge short

endpackage

// File: logic/phase_tracker.sv
`timescale 1ns/100ps

module phase_tracker (
   input  logic                                                clock,
   input  logic                                                reset,
   input  logic                                                enable,
   input  logic                [capture_pkg::channels-1:0]     synced,
   input  logic                [capture_pkg::channels-1:0]     edge_pulse,
   output capture_pkg::phase_t                                 phase,
   output capture_pkg::phase_t [capture_pkg::channels-1:0]     sample_phase,
   output logic                [capture_pkg::channels-1:0]     channel_valid,
   output logic                [capture_pkg::channels-1:0]     synced_delay
);

   // ######################################################################
   // free-running symbol counter shared by all channels

   always_ff @(posedge clock) begin
      if (reset) begin
         phase <= '0;
      end else if (enable) begin
         if (phase == capture_pkg::last_phase) begin
            phase <= '0;                         // start of the next symbol period
         end else begin
            phase <= phase + 1'b1;
         end
      end
   end

   // the level is delayed once so that it lines up with the counter
   always_ff @(posedge clock) begin
      if (enable) begin
         synced_delay <= synced;
      end
   end

   assert property (@(posedge clock) disable iff (reset)
      phase <= capture_pkg::last_phase)
      else $error("phase_tracker: phase counter left the symbol range");

   // ######################################################################
   // per-channel edge phase estimate and lock confidence

   for (genvar i = 0; i < capture_pkg::channels; i++) begin : channel
      capture_pkg::phase_t   stored;             // counter value seen at the edges
      lock_pkg::confidence_t confidence;         // consecutive consistent edges
      logic                  valid;              // this channel has a trusted phase
      logic                  consistent;         // edge lands near the stored phase

      assign consistent = capture_pkg::phase_dist(phase, stored)
                          <= capture_pkg::phase_t'(lock_pkg::phase_tolerance);

      always_ff @(posedge clock) begin
         if (reset) begin
            stored     <= '0;
            confidence <= '0;
            valid      <= 1'b0;
         end else if (enable && edge_pulse[i]) begin
            if (consistent) begin
               if (confidence != lock_pkg::confidence_full) begin
                  confidence <= confidence + 1'b1;   // saturates, never wraps to zero
               end
               if (confidence >= lock_pkg::lock_arm) begin
                  valid <= 1'b1;                 // this edge is the lock_edges-th one
               end
            end else begin
               stored     <= phase;              // jump to the new bit phase
               confidence <= '0;
               valid      <= 1'b0;               // channel has to earn its lock again
            end
         end
      end

      assign channel_valid[i] = valid;

      // mid-bit lies half a symbol after the edge
      assign sample_phase[i] = capture_pkg::phase_add(stored, capture_pkg::half_ratio);

      assert property (@(posedge clock) disable iff (reset)
         $rose(valid) |-> confidence >= lock_pkg::lock_target)
         else $error("phase_tracker: channel %0d valid before enough edges", i);
   end

endmodule

// File: logic/sample_align.sv
`timescale 1ns/100ps

module sample_align (
   input  logic                                                clock,
   input  logic                                                reset,
   input  logic                                                enable,
   input  capture_pkg::phase_t                                 phase,
   input  capture_pkg::phase_t [capture_pkg::channels-1:0]     sample_phase,
   input  logic                [capture_pkg::channels-1:0]     channel_valid,
   input  logic                [capture_pkg::channels-1:0]     synced_delay,
   output logic                [capture_pkg::channels-1:0]     word,
   output logic                                                strobe,
   output logic                                                locked
);

   logic [capture_pkg::channels-1:0] samples;    // latest mid-bit value of each channel
   capture_pkg::phase_t              load_phase; // one cycle before the strobe phase
   logic                             all_valid;  // every channel has a trusted phase
   logic                             load;       // word takes the samples this cycle
   logic                             strobe_q;   // registered strobe, word is out with it

   // ######################################################################
   // mid-bit samplers

   always_ff @(posedge clock) begin
      if (enable) begin
         for (int i = 0; i < capture_pkg::channels; i++) begin
            if (phase == sample_phase[i]) begin
               samples[i] <= synced_delay[i];    // centre of this channel's bit
            end
         end
      end
   end

   // ######################################################################
   // common strobe, lock flag and word register

   assign all_valid = &channel_valid;

   // channel 0 decides the strobe phase, half a symbol past its own sample point,
   // the word is loaded one cycle early so that it is out together with strobe
   assign load_phase = capture_pkg::phase_add(sample_phase[0],
                                              capture_pkg::half_ratio - 1'b1);

   // all_valid too, so that a channel dropping out stops the strobe at once
   assign load = enable & locked & all_valid & (phase == load_phase);

   always_ff @(posedge clock) begin
      if (reset) begin
         locked   <= 1'b0;
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= load;                       // one cycle pulse per symbol
         if (enable) begin
            locked <= all_valid;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (load) begin
         word <= samples;                        // every channel is on the same symbol
      end
   end

   assign strobe = strobe_q & enable;            // no strobe while the capture is held

   assert property (@(posedge clock) disable iff (reset)
      strobe |-> locked)
      else $error("sample_align: strobe issued without lock");

   // locked lags all_valid by a cycle, a channel that just jumped is already invalid
   for (genvar i = 1; i < capture_pkg::channels; i++) begin : skew_check
      assert property (@(posedge clock) disable iff (reset)
         locked && all_valid
            |-> capture_pkg::phase_dist(sample_phase[i], sample_phase[0])
                <= capture_pkg::phase_t'(capture_pkg::max_skew
                                         + lock_pkg::phase_tolerance))
         else $error("sample_align: channel %0d skew too large for alignment", i);
   end

endmodule

// File: logic/signal_capture.sv
`timescale 1ns/100ps

module signal_capture (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             enable,
   input  logic [capture_pkg::channels-1:0] signal_in,
   output logic [capture_pkg::channels-1:0] word,
   output logic                             strobe,
   output logic                             locked
);

   logic                [capture_pkg::channels-1:0] synced;        // clean channel levels
   logic                [capture_pkg::channels-1:0] edge_pulse;    // one pulse per transition
   capture_pkg::phase_t                             phase;         // shared symbol counter
   capture_pkg::phase_t [capture_pkg::channels-1:0] sample_phase;  // mid-bit of each channel
   logic                [capture_pkg::channels-1:0] channel_valid; // per-channel lock
   logic                [capture_pkg::channels-1:0] synced_delay;  // levels aligned to phase

   // ######################################################################
   // synchronise, track the bit phase, sample and align

   capture_sync sync_stage (
      .clock      (clock),
      .reset      (reset),
      .enable     (enable),
      .signal_in  (signal_in),
      .synced     (synced),
      .edge_pulse (edge_pulse)
   );

   phase_tracker track_stage (
      .clock         (clock),
      .reset         (reset),
      .enable        (enable),
      .synced        (synced),
      .edge_pulse    (edge_pulse),
      .phase         (phase),
      .sample_phase  (sample_phase),
      .channel_valid (channel_valid),
      .synced_delay  (synced_delay)
   );

   sample_align align_stage (
      .clock         (clock),
      .reset         (reset),
      .enable        (enable),
      .phase         (phase),
      .sample_phase  (sample_phase),
      .channel_valid (channel_valid),
      .synced_delay  (synced_delay),
      .word          (word),
      .strobe        (strobe),
      .locked        (locked)
   );

endmodule

// File: project.f
logic/capture_pkg.sv
logic/lock_pkg.sv
logic/capture_sync.sv
logic/phase_tracker.sv
logic/sample_align.sv
logic/signal_capture.sv
tests/fake_antenna.sv
tests/signal_capture_tb.sv

// File: tests/fake_antenna.sv
`timescale 1ns/100ps

module fake_antenna (
   input  logic                             clock,
   input  logic                             jitter_on,   // move edges by up to one cycle
   input  int                               extra_delay, // common delay step, in cycles
   output logic [capture_pkg::channels-1:0] signal_out,
   output logic [capture_pkg::channels-1:0] symbol,
   output logic                             symbol_new
);

   localparam int depth = capture_pkg::ratio / 2 + capture_pkg::max_skew + 2;

   logic [capture_pkg::channels-1:0] history [depth];  // history[0] is the newest level
   logic [capture_pkg::channels-1:0] current;          // symbol now on the air
   logic [31:0]                      draw;             // raw random word
   int                               offset [capture_pkg::channels]; // fixed per channel
   int                               countdown;        // cycles left in this symbol
   int                               delay;            // total delay of one channel
   bit                               started;          // offsets drawn on the first edge

   initial begin
      signal_out = '0;
      symbol     = '0;
      symbol_new = 1'b0;
      current    = '0;
      started    = 1'b0;
      for (int k = 0; k < depth; k++) begin
         history[k] = '0;
      end
   end

   // ######################################################################
   // symbol source, per-channel delay line and jitter

   always @(posedge clock) begin
      #1;                                         // drive a little after the edge
      if (!started) begin
         for (int c = 0; c < capture_pkg::channels; c++) begin
            offset[c] = $urandom_range(capture_pkg::max_skew, 0);
         end
         countdown = $urandom_range(capture_pkg::ratio - 1, 0);  // random start phase
         started   = 1'b1;
      end
      symbol_new = 1'b0;
      if (countdown == 0) begin
         draw       = $urandom;
         current    = draw[capture_pkg::channels-1:0];
         symbol     = current;                    // the testbench queues this word
         symbol_new = 1'b1;
         countdown  = capture_pkg::ratio - 1;
      end else begin
         countdown = countdown - 1;
      end
      for (int k = depth - 1; k > 0; k--) begin
         history[k] = history[k-1];
      end
      history[0] = current;
      // a delay that changes by one at most never makes a glitch, only moves an edge
      for (int c = 0; c < capture_pkg::channels; c++) begin
         delay = offset[c] + extra_delay;
         if (jitter_on) begin
            delay = delay + $urandom_range(1, 0);
         end
         signal_out[c] = history[delay][c];
      end
   end

endmodule

// File: tests/signal_capture_tb.sv
`timescale 1ns/100ps

module signal_capture_tb;

   localparam int timeout_cycles = 40 * capture_pkg::ratio;  // 40 symbol periods

   logic                             clock;
   logic                             reset;
   logic                             enable;
   logic [capture_pkg::channels-1:0] signal_in;
   logic [capture_pkg::channels-1:0] word;
   logic                             strobe;
   logic                             locked;
   logic                             jitter_on;
   int                               extra_delay;
   logic [capture_pkg::channels-1:0] symbol;
   logic                             symbol_new;
   logic [capture_pkg::channels-1:0] symbols [$];  // every word the antenna sent
   int                               cycle;
   int                               errors;
   int                               tests_run;
   int                               tests_failed;
   int                               mark;

   fake_antenna antenna_i (
      .clock       (clock),
      .jitter_on   (jitter_on),
      .extra_delay (extra_delay),
      .signal_out  (signal_in),
      .symbol      (symbol),
      .symbol_new  (symbol_new)
   );

   signal_capture signal_capture_i (
      .clock     (clock),
      .reset     (reset),
      .enable    (enable),
      .signal_in (signal_in),
      .word      (word),
      .strobe    (strobe),
      .locked    (locked)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // symbol_new is stable at the edge, the checks look at the queue on falling edges
   always @(posedge clock) begin
      cycle = cycle + 1;
      if (symbol_new) begin
         symbols.push_back(symbol);
      end
   end

   // ######################################################################
   // helpers

   task automatic report_test(input string name, input int errors_before);
      tests_run = tests_run + 1;
      if (errors == errors_before) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_before);
      end
   endtask

   task automatic expect_idle(input int cycles, input string what);
      repeat (cycles) begin
         @(negedge clock);
         if (strobe || locked) begin
            $display("strobe or locked went high %s at %0t", what, $time);
            errors = errors + 1;
         end
      end
   endtask

   task automatic wait_locked(input logic level, input string what);
      int waited;
      waited = 0;
      while (locked !== level && waited < timeout_cycles) begin
         @(negedge clock);
         waited = waited + 1;
         if (strobe && !locked) begin
            $display("strobe seen without lock at %0t", $time);
            errors = errors + 1;
         end
      end
      if (locked !== level) begin
         $display("timed out waiting for %s at %0t", what, $time);
         errors = errors + 1;
      end
   endtask

   // the first word fixes the lag, every later word must be the next queued symbol
   task automatic check_words(input int count);
      int waited;
      int seen;
      int index;
      int last_strobe;
      waited      = 0;
      seen        = 0;
      index       = -1;
      last_strobe = -1;
      while (seen < count) begin
         @(negedge clock);
         waited = waited + 1;
         if (!locked) begin
            $display("locked fell during the word check at %0t", $time);
            errors = errors + 1;
            return;
         end
         if (waited > timeout_cycles) begin
            $display("timed out waiting for a strobe at %0t", $time);
            errors = errors + 1;
            return;
         end
         if (strobe) begin
            waited = 0;
            if (last_strobe >= 0 && cycle - last_strobe != capture_pkg::ratio) begin
               $display("** Error at %0t: strobe spacing expected %0d actual %0d",
                        $time, capture_pkg::ratio, cycle - last_strobe);
               errors = errors + 1;
            end
            last_strobe = cycle;
            if (index < 0) begin
               for (int k = 1; k <= 3 && index < 0; k++) begin
                  if (symbols.size() >= k && word == symbols[symbols.size()-k]) begin
                     index = symbols.size() - k;
                  end
               end
               if (index < 0) begin
                  $display("first word %h after lock matches no recent symbol at %0t",
                           word, $time);
                  errors = errors + 1;
                  return;
               end
            end else begin
               index = index + 1;
               if (index >= symbols.size()) begin
                  $display("word arrived before its symbol was sent at %0t", $time);
                  errors = errors + 1;
                  return;
               end
               if (word != symbols[index]) begin
                  $display("** Error at %0t: word expected %h actual %h",
                           $time, symbols[index], word);
                  errors = errors + 1;
               end
            end
            seen = seen + 1;
         end
      end
   endtask

   // ######################################################################
   // scenarios

   initial begin
      void'($urandom(32'h21df043f));
      reset        = 1'b1;
      enable       = 1'b0;
      jitter_on    = 1'b0;
      extra_delay  = 0;
      cycle        = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;

      mark = errors;
      repeat (3) begin
         @(posedge clock);
         #1;
         if (strobe || locked) begin
            $display("strobe or locked high during reset at %0t", $time);
            errors = errors + 1;
         end
      end
      reset = 1'b0;
      expect_idle(5 * capture_pkg::ratio, "while enable is low");
      report_test("idle through reset and hold", mark);

      mark = errors;
      @(posedge clock);
      #1;
      enable = 1'b1;
      wait_locked(1'b1, "first lock");
      repeat (2 * capture_pkg::ratio) begin
         @(negedge clock);
         if (!locked) begin
            $display("locked dropped after first lock at %0t", $time);
            errors = errors + 1;
         end
      end
      report_test("lock with fixed offsets", mark);

      mark = errors;
      check_words(50);
      report_test("aligned words without jitter", mark);

      mark = errors;
      @(negedge clock);
      jitter_on = 1'b1;                              // antenna picks it up on the next edge
      check_words(200);
      report_test("aligned words with edge jitter", mark);

      mark = errors;
      @(negedge clock);
      extra_delay = capture_pkg::ratio / 2;          // half a symbol on the antenna delay
      wait_locked(1'b0, "lock loss after the step");
      wait_locked(1'b1, "relock after the step");
      check_words(50);
      report_test("relock after a phase step", mark);

      mark = errors;
      @(posedge clock);
      #1;
      enable = 1'b0;                                 // hold the capture while it is locked
      repeat (3 * capture_pkg::ratio) begin
         @(negedge clock);
         if (strobe) begin
            $display("strobe seen while enable is low at %0t", $time);
            errors = errors + 1;
         end
      end
      report_test("no strobe while held after lock", mark);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
